/* sim.f */
hw/arch_defs_pkg.sv
hw/uart_wb_regs.sv
hw/uart_receiver.sv
hw/uart_transmitter.sv
hw/uart_top.sv
tb/tb_clock_gen.sv
tb/tb_uart_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Finished with errors"

verilator --binary --timing --assert --top-module tb_uart_top --Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_uart_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "$FAIL_TEXT" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* tb/tb_uart_top.sv */
module tb_uart_top import arch_defs_pkg::*; ();

    localparam int CLOCK_SPEED       = 1_600_000;
    localparam int BAUD_RATE         = 25_000;
    localparam int OVERSAMPLING_RATE = 16;
    localparam int CYCLES_PER_SAMPLE = CLOCK_SPEED / (BAUD_RATE * OVERSAMPLING_RATE);
    localparam int BIT_CLOCKS        = CYCLES_PER_SAMPLE * OVERSAMPLING_RATE;   // 64
    localparam int DRIVE_DELAY       = 2;
    localparam int ACK_TIMEOUT       = 20;     // Clocks
    localparam int POLL_LIMIT        = 1000;   // Status reads
    localparam int FRAME_TIMEOUT     = 12 * BIT_CLOCKS;

    logic    clk;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    rx_serial;
    logic    tx_serial;

    logic [31:0] rng_state;
    logic [7:0]  tx_seen[$];    // Bytes recovered by the line monitor
    logic [7:0]  model_rx_byte;
    logic [7:0]  model_tx_byte;
    logic        model_rx_valid;
    logic        model_frame_err;
    logic        model_overrun;

    tb_clock_gen u_clk_gen (.clk(clk), .reset(reset));

    uart_top #(
        .CLOCK_SPEED       (CLOCK_SPEED),
        .BAUD_RATE         (BAUD_RATE),
        .OVERSAMPLING_RATE (OVERSAMPLING_RATE)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .i_rx_serial (rx_serial),
        .o_tx_serial (tx_serial)
    );

    // ================================================
    // Reporting and model
    // ================================================
    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at time %0t while waiting for %s", $time, what);
        end_with_failure();
    endtask

    task automatic check_equal(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp) else begin
            $display("ERROR at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // rx_valid, tx_busy, frame_err, overrun from bit 0 up
    function automatic logic [7:0] expected_status(input logic tx_busy);
        return {4'b0, model_overrun, model_frame_err, tx_busy, model_rx_valid};
    endfunction

    function automatic void model_frame(input logic [7:0] data, input logic good_stop);
        model_overrun   = 1'b0;   // Any valid start clears status
        model_frame_err = !good_stop;
        if (good_stop) begin
            model_overrun  = model_rx_valid;
            model_rx_valid = 1'b1;
            model_rx_byte  = data;
        end
    endfunction

    // ================================================
    // Bus driver
    // ================================================
    task automatic bus_access(input logic we, input uart_reg_addr_t addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat_w: wdata};
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            report_timeout("Wishbone ack");
        end else begin
            rdata = wb_rsp.dat_r;
            @(posedge clk);
            #DRIVE_DELAY;
            wb_req = '0;   // Cycle after ack
        end
    endtask

    task automatic write_reg(input uart_reg_addr_t addr, input logic [7:0] data);
        logic [7:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input uart_reg_addr_t addr, output logic [7:0] data);
        bus_access(1'b0, addr, 8'h00, data);
    endtask

    task automatic poll_status(input int bit_idx, input logic level, input string what,
                               output logic [7:0] st);
        int polls;
        polls = 0;
        do begin
            read_reg(REG_STATUS, st);
            polls++;
        end while (st[bit_idx] !== level && polls < POLL_LIMIT);
        if (st[bit_idx] !== level) report_timeout(what);
    endtask

    // ================================================
    // Serial line model
    // ================================================
    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        logic [9:0] frame;
        frame = {stop_level, data, 1'b0};   // Start bit goes first
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            rx_serial = frame[i];
            repeat (BIT_CLOCKS - 1) @(posedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rx_serial = 1'b1;
    endtask

    task automatic send_glitch(input int low_clocks);
        @(posedge clk);
        #DRIVE_DELAY;
        rx_serial = 1'b0;
        repeat (low_clocks) @(posedge clk);
        #DRIVE_DELAY;
        rx_serial = 1'b1;
    endtask

    task automatic wait_tx_frame(output logic [7:0] data);
        int waited;
        waited = 0;
        data   = '0;
        while (tx_seen.size() == 0 && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_seen.size() == 0) begin
            report_timeout("a frame on o_tx_serial");
        end else begin
            data = tx_seen.pop_front();
        end
    endtask

    // Samples at bit middles, counted from the falling edge
    initial begin : line_monitor
        logic       prev;
        logic [7:0] bits;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (!reset && prev && !tx_serial) begin
                repeat (BIT_CLOCKS / 2) @(negedge clk);
                check_equal({7'b0, tx_serial}, 8'h00, "tx start bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLOCKS) @(negedge clk);
                    bits[i] = tx_serial;   // LSB first
                end
                repeat (BIT_CLOCKS) @(negedge clk);
                check_equal({7'b0, tx_serial}, 8'h01, "tx stop bit");
                tx_seen.push_back(bits);
            end
            prev = tx_serial;
        end
    end

    // ================================================
    // Test sequence
    // ================================================
    initial begin : main
        logic [7:0] rd;
        logic [7:0] b;
        int         waited;
        rng_state       = 32'd85;
        wb_req          = '0;
        rx_serial       = 1'b1;
        model_rx_byte   = '0;
        model_tx_byte   = '0;
        model_rx_valid  = 1'b0;
        model_frame_err = 1'b0;
        model_overrun   = 1'b0;
        waited          = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (reset !== 1'b0 && waited < 20);
        if (reset !== 1'b0) report_timeout("reset release");

        read_reg(REG_STATUS, rd);
        check_equal(rd, 8'h00, "STATUS after reset");
        check_equal({7'b0, tx_serial}, 8'h01, "tx line after reset");

        repeat (20) begin
            model_tx_byte = random_byte();
            write_reg(REG_DATA, model_tx_byte);
            read_reg(REG_STATUS, rd);
            check_equal(rd, expected_status(1'b1), "STATUS during transmit");
            wait_tx_frame(rd);
            check_equal(rd, model_tx_byte, "transmitted byte");
            poll_status(1, 1'b0, "tx_busy to clear", rd);
            check_equal(rd, expected_status(1'b0), "STATUS after transmit");
        end

        repeat (20) begin
            b = random_byte();
            send_frame(b, 1'b1);
            model_frame(b, 1'b1);
            poll_status(0, 1'b1, "rx_valid", rd);
            check_equal(rd, expected_status(1'b0), "STATUS after frame");
            read_reg(REG_DATA, rd);
            check_equal(rd, model_rx_byte, "received byte");
            model_rx_valid = 1'b0;
            read_reg(REG_STATUS, rd);
            check_equal(rd, expected_status(1'b0), "STATUS after DATA read");
        end

        // Bad stop bit, then a short glitch
        b = random_byte();
        send_frame(b, 1'b0);
        model_frame(b, 1'b0);
        poll_status(2, 1'b1, "frame_err", rd);
        check_equal(rd, expected_status(1'b0), "STATUS after bad stop bit");
        send_glitch(BIT_CLOCKS / 4);
        repeat (10 * BIT_CLOCKS) @(posedge clk);
        read_reg(REG_STATUS, rd);
        check_equal(rd, expected_status(1'b0), "STATUS after glitch");
        b = random_byte();
        send_frame(b, 1'b1);
        model_frame(b, 1'b1);
        poll_status(0, 1'b1, "rx_valid after frame error", rd);
        check_equal(rd, expected_status(1'b0), "STATUS after recovery frame");
        read_reg(REG_DATA, rd);
        check_equal(rd, model_rx_byte, "byte after frame error");
        model_rx_valid = 1'b0;

        // Two frames with no read in between
        b = random_byte();
        send_frame(b, 1'b1);
        model_frame(b, 1'b1);
        poll_status(0, 1'b1, "first overrun frame", rd);
        b = random_byte();
        send_frame(b, 1'b1);
        model_frame(b, 1'b1);
        poll_status(3, 1'b1, "overrun", rd);
        check_equal(rd, expected_status(1'b0), "STATUS with overrun");
        read_reg(REG_DATA, rd);
        check_equal(rd, model_rx_byte, "byte kept after overrun");
        model_rx_valid = 1'b0;
        read_reg(REG_STATUS, rd);
        check_equal(rd, expected_status(1'b0), "STATUS after overrun read");

        // Second write lands while the first frame is on the line
        model_tx_byte = random_byte();
        write_reg(REG_DATA, model_tx_byte);
        write_reg(REG_DATA, random_byte());
        read_reg(REG_STATUS, rd);
        check_equal(rd, expected_status(1'b1), "STATUS after write while busy");
        wait_tx_frame(rd);
        check_equal(rd, model_tx_byte, "byte sent before dropped write");
        poll_status(1, 1'b0, "tx_busy after dropped write", rd);
        repeat (2 * BIT_CLOCKS) begin
            @(negedge clk);
            check_equal({7'b0, tx_serial}, 8'h01, "idle line after dropped write");
        end
        check_equal(8'(tx_seen.size()), 8'h00, "extra frames on the line");

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 20;   // Period 40
    localparam int RESET_DELAY = 2;    // Release just after the edge

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #RESET_DELAY;
        reset = 1'b0;
    end

endmodule

/* hw/uart_top.sv */
module uart_top import arch_defs_pkg::*; #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16
) (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb,
    input  logic    i_rx_serial,
    output logic    o_tx_serial
);

    // ================================================
    // Internal links
    // ================================================
    logic                  rx_strobe;
    logic [DATA_WIDTH-1:0] rx_data;
    uart_rx_status_t       rx_status;
    logic                  rx_unread;    // rx_valid back to the receiver
    logic                  tx_start;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  tx_busy;

    uart_wb_regs u_regs (
        .clk                    (clk),
        .reset                  (reset),
        .i_wb                   (i_wb),
        .o_wb                   (o_wb),
        .i_rx_strobe_data_ready (rx_strobe),
        .i_rx_parallel_data     (rx_data),
        .i_rx_status            (rx_status),
        .o_rx_unread            (rx_unread),
        .o_tx_start             (tx_start),
        .o_tx_data              (tx_data),
        .i_tx_busy              (tx_busy)
    );

    uart_receiver #(
        .CLOCK_SPEED       (CLOCK_SPEED),
        .BAUD_RATE         (BAUD_RATE),
        .OVERSAMPLING_RATE (OVERSAMPLING_RATE),
        .WORD_SIZE         (DATA_WIDTH)
    ) u_rx (
        .clk                    (clk),
        .reset                  (reset),
        .i_rx_serial_in_data    (i_rx_serial),
        .i_rx_unread            (rx_unread),
        .o_rx_strobe_data_ready (rx_strobe),
        .o_rx_parallel_data_out (rx_data),
        .o_rx_status_reg        (rx_status)
    );

    uart_transmitter #(
        .CLOCK_SPEED       (CLOCK_SPEED),
        .BAUD_RATE         (BAUD_RATE),
        .OVERSAMPLING_RATE (OVERSAMPLING_RATE),
        .WORD_SIZE         (DATA_WIDTH)
    ) u_tx (
        .clk         (clk),
        .reset       (reset),
        .i_tx_start  (tx_start),
        .i_tx_data   (tx_data),
        .o_tx_busy   (tx_busy),
        .o_tx_serial (o_tx_serial)
    );

endmodule

/* hw/uart_transmitter.sv */
module uart_transmitter import arch_defs_pkg::*; #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16,
    parameter int WORD_SIZE         = DATA_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_tx_start,
    input  logic [WORD_SIZE-1:0] i_tx_data,
    output logic                 o_tx_busy,
    output logic                 o_tx_serial
);

    localparam int CYCLES_PER_SAMPLE = CLOCK_SPEED / (BAUD_RATE * OVERSAMPLING_RATE);
    localparam int BIT_PERIOD = CYCLES_PER_SAMPLE * OVERSAMPLING_RATE;   // Clocks per bit
    localparam int CYC_W = (BIT_PERIOD > 1) ? $clog2(BIT_PERIOD) : 1;
    localparam int IDX_W = (WORD_SIZE > 1) ? $clog2(WORD_SIZE) : 1;

    localparam logic [CYC_W-1:0] LAST_CYCLE = CYC_W'(BIT_PERIOD - 1);
    localparam logic [IDX_W-1:0] LAST_BIT   = IDX_W'(WORD_SIZE - 1);

    uart_tx_state_t       state;
    logic [CYC_W-1:0]     cycle_count;
    logic [IDX_W-1:0]     bit_index;
    logic [WORD_SIZE-1:0] tx_shift;    // Next data bit sits in bit 0
    logic                 bit_done;
    logic                 load;

    assign bit_done  = (cycle_count == LAST_CYCLE);
    assign load      = (state == S_UART_TX_IDLE) && i_tx_start;
    assign o_tx_busy = (state != S_UART_TX_IDLE);

    // ================================================
    // Bit timing and framing FSM
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_UART_TX_IDLE;
            cycle_count <= '0;
            bit_index   <= '0;
            o_tx_serial <= 1'b1;
        end else begin
            if ((state == S_UART_TX_IDLE) || bit_done) begin
                cycle_count <= '0;
            end else begin
                cycle_count <= cycle_count + 1'b1;
            end

            case (state)
                S_UART_TX_IDLE: begin
                    if (i_tx_start) begin
                        state       <= S_UART_TX_START;
                        o_tx_serial <= 1'b0;   // Start bit
                    end
                end

                S_UART_TX_START: begin
                    if (bit_done) begin
                        state       <= S_UART_TX_DATA;
                        bit_index   <= '0;
                        o_tx_serial <= tx_shift[0];
                    end
                end

                S_UART_TX_DATA: begin
                    if (bit_done) begin
                        if (bit_index == LAST_BIT) begin
                            state       <= S_UART_TX_STOP;
                            o_tx_serial <= 1'b1;
                        end else begin
                            bit_index   <= bit_index + 1'b1;
                            o_tx_serial <= tx_shift[0];
                        end
                    end
                end

                S_UART_TX_STOP: begin
                    if (bit_done) state <= S_UART_TX_IDLE;   // Line already high
                end

                default: begin
                    state       <= S_UART_TX_IDLE;
                    o_tx_serial <= 1'b1;
                end
            endcase
        end
    end

    // Latched copy of the byte, shifted as each bit goes out
    always_ff @(posedge clk) begin
        if (load) begin
            tx_shift <= i_tx_data;
        end else if (bit_done && ((state == S_UART_TX_START) || (state == S_UART_TX_DATA))) begin
            tx_shift <= tx_shift >> 1;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
        (state == S_UART_TX_IDLE) |-> o_tx_serial);

endmodule

/* hw/uart_receiver.sv */
module uart_receiver import arch_defs_pkg::*; #(
    parameter int CLOCK_SPEED       = 20_000_000,
    parameter int BAUD_RATE         = 9600,
    parameter int OVERSAMPLING_RATE = 16,
    parameter int WORD_SIZE         = DATA_WIDTH
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_rx_serial_in_data,
    input  logic                 i_rx_unread,
    output logic                 o_rx_strobe_data_ready,
    output logic [WORD_SIZE-1:0] o_rx_parallel_data_out,
    output uart_rx_status_t      o_rx_status_reg
);

    localparam int CYCLES_PER_SAMPLE = CLOCK_SPEED / (BAUD_RATE * OVERSAMPLING_RATE);
    localparam int TIMER_W  = (CYCLES_PER_SAMPLE > 1) ? $clog2(CYCLES_PER_SAMPLE) : 1;
    localparam int SAMPLE_W = (OVERSAMPLING_RATE > 1) ? $clog2(OVERSAMPLING_RATE) : 1;
    localparam int BIT_CNT_W = (WORD_SIZE > 1) ? $clog2(WORD_SIZE) : 1;

    localparam logic [TIMER_W-1:0]   LAST_TICK   = TIMER_W'(CYCLES_PER_SAMPLE - 1);
    localparam logic [SAMPLE_W-1:0]  MID_SAMPLE  = SAMPLE_W'(OVERSAMPLING_RATE / 2 - 1);
    localparam logic [SAMPLE_W-1:0]  LAST_SAMPLE = SAMPLE_W'(OVERSAMPLING_RATE - 1);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT    = BIT_CNT_W'(WORD_SIZE - 1);

    localparam logic LINE_IDLE = 1'b1;
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;

    // ================================================
    // Input synchronizer and start edge
    // ================================================
    logic sync_ff1;
    logic synced_serial;
    logic synced_prev;   // For falling edge only
    logic start_edge;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_ff1      <= LINE_IDLE;
            synced_serial <= LINE_IDLE;
            synced_prev   <= LINE_IDLE;
        end else begin
            sync_ff1      <= i_rx_serial_in_data;
            synced_serial <= sync_ff1;
            synced_prev   <= synced_serial;
        end
    end

    // A low tail after a bad stop bit is not a new start
    assign start_edge = (synced_prev == LINE_IDLE) && (synced_serial == START_BIT);

    // ================================================
    // Sample timer
    // ================================================
    logic [TIMER_W-1:0]  timer;
    logic [SAMPLE_W-1:0] sample_count;
    logic                timer_clear;
    logic                timer_run;
    logic                sample_tick;
    logic                event_middle_of_bit;
    logic                event_end_of_bit;

    assign sample_tick         = timer_run && (timer == LAST_TICK);
    assign event_middle_of_bit = sample_tick && (sample_count == MID_SAMPLE);
    assign event_end_of_bit    = sample_tick && (sample_count == LAST_SAMPLE);

    always_ff @(posedge clk) begin
        if (reset || timer_clear) begin
            timer        <= '0;
            sample_count <= '0;
        end else if (sample_tick) begin
            timer        <= '0;
            sample_count <= (sample_count == LAST_SAMPLE) ? '0 : sample_count + 1'b1;
        end else if (timer_run) begin
            timer <= timer + 1'b1;
        end
    end

    // ================================================
    // Control FSM
    // ================================================
    uart_fsm_state_t      state, next_state;
    logic [BIT_CNT_W-1:0] bit_count, next_bit_count;
    logic                 shift_en;
    logic                 flag_frame_err;
    logic                 clear_status;

    always_comb begin
        next_state     = state;
        next_bit_count = bit_count;
        timer_clear    = 1'b0;
        timer_run      = 1'b0;
        shift_en       = 1'b0;
        flag_frame_err = 1'b0;
        clear_status   = 1'b0;

        case (state)
            S_UART_RX_IDLE: begin
                if (start_edge) begin
                    next_state  = S_UART_RX_VALIDATE_START;
                    timer_clear = 1'b1;
                end
            end

            S_UART_RX_VALIDATE_START: begin
                timer_run = 1'b1;
                if (event_middle_of_bit) begin
                    if (synced_serial == START_BIT) begin
                        next_state     = S_UART_RX_READ_DATA;
                        next_bit_count = '0;
                        timer_clear    = 1'b1;   // Realign to mid-bit
                        clear_status   = 1'b1;
                    end else begin
                        next_state = S_UART_RX_IDLE;   // Glitch
                    end
                end
            end

            S_UART_RX_READ_DATA: begin
                timer_run = 1'b1;
                if (event_end_of_bit) begin
                    shift_en = 1'b1;
                    if (bit_count == LAST_BIT) begin
                        next_state = S_UART_RX_STOP;
                    end else begin
                        next_bit_count = bit_count + 1'b1;
                    end
                end
            end

            S_UART_RX_STOP: begin
                timer_run = 1'b1;
                if (event_end_of_bit) begin
                    if (synced_serial == STOP_BIT) begin
                        next_state = S_UART_RX_DATA_READY;
                    end else begin
                        next_state     = S_UART_RX_IDLE;
                        flag_frame_err = 1'b1;
                    end
                end
            end

            S_UART_RX_DATA_READY: next_state = S_UART_RX_IDLE;

            default: next_state = S_UART_RX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_UART_RX_IDLE;
            bit_count <= '0;
        end else begin
            state     <= next_state;
            bit_count <= next_bit_count;
        end
    end

    // ================================================
    // Data path and status
    // ================================================
    logic [WORD_SIZE-1:0] rx_shift_reg;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            rx_shift_reg <= {synced_serial, rx_shift_reg[WORD_SIZE-1:1]};   // LSB first
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear_status) begin
            o_rx_status_reg <= '0;
        end else begin
            if (flag_frame_err) o_rx_status_reg.frame_err <= 1'b1;
            // Previous byte still unread at completion
            if ((state == S_UART_RX_DATA_READY) && i_rx_unread) begin
                o_rx_status_reg.overrun <= 1'b1;
            end
        end
    end

    assign o_rx_parallel_data_out = rx_shift_reg;
    assign o_rx_strobe_data_ready = (state == S_UART_RX_DATA_READY);

    a_strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        o_rx_strobe_data_ready |=> !o_rx_strobe_data_ready);

endmodule

/* hw/uart_wb_regs.sv */
module uart_wb_regs import arch_defs_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    // Bus side
    input  wb_req_t               i_wb,
    output wb_rsp_t               o_wb,

    // Receiver side
    input  logic                  i_rx_strobe_data_ready,
    input  logic [DATA_WIDTH-1:0] i_rx_parallel_data,
    input  uart_rx_status_t       i_rx_status,
    output logic                  o_rx_unread,

    // Transmitter side
    output logic                  o_tx_start,
    output logic [DATA_WIDTH-1:0] o_tx_data,
    input  logic                  i_tx_busy
);

    logic                  ack_q;
    logic [DATA_WIDTH-1:0] rd_data_q;    // Captured when the request is accepted
    logic [DATA_WIDTH-1:0] rx_hold;      // Last received byte
    logic                  rx_valid;
    logic                  req_accept;
    logic                  data_write;
    logic                  data_read;
    uart_reg_addr_t        reg_addr;
    logic [DATA_WIDTH-1:0] status_word;
    logic [DATA_WIDTH-1:0] rd_mux;

    // ================================================
    // Request decode
    // ================================================
    assign reg_addr   = uart_reg_addr_t'(i_wb.adr);
    assign req_accept = i_wb.cyc && i_wb.stb && !ack_q;   // Every access takes two cycles
    assign data_write = req_accept && i_wb.we && (reg_addr == REG_DATA);
    assign data_read  = req_accept && !i_wb.we && (reg_addr == REG_DATA);

    // Status word: rx_valid, tx_busy, frame_err, overrun, rest zero
    always_comb begin
        status_word    = '0;
        status_word[0] = rx_valid;
        status_word[1] = i_tx_busy;
        status_word[2] = i_rx_status.frame_err;
        status_word[3] = i_rx_status.overrun;
    end

    always_comb begin
        case (reg_addr)
            REG_DATA:   rd_mux = rx_hold;
            REG_STATUS: rd_mux = status_word;
            default:    rd_mux = '0;
        endcase
    end

    // ================================================
    // Bus response
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_accept;   // High for exactly one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept && !i_wb.we) begin
            rd_data_q <= rd_mux;
        end
    end

    assign o_wb = '{ack: ack_q, dat_r: rd_data_q};

    // ================================================
    // Receive holding register
    // ================================================
    always_ff @(posedge clk) begin
        if (i_rx_strobe_data_ready) begin
            rx_hold <= i_rx_parallel_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else if (i_rx_strobe_data_ready) begin
            rx_valid <= 1'b1;   // A fresh byte wins over a read
        end else if (data_read) begin
            rx_valid <= 1'b0;
        end
    end

    assign o_rx_unread = rx_valid;

    // Transmit start, a write while busy is acked and dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= data_write && !i_tx_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (data_write && !i_tx_busy) begin
            o_tx_data <= i_wb.dat_w;
        end
    end

    a_ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        o_wb.ack |=> !o_wb.ack);

    // Transmitter must be idle whenever a start is issued
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        o_tx_start |-> !i_tx_busy);

endmodule

/* hw/arch_defs_pkg.sv */
package arch_defs_pkg;

    // ================================================
    // Widths
    // ================================================
    localparam int DATA_WIDTH    = 8;   // Serial character and bus data
    localparam int WB_ADDR_WIDTH = 1;   // Word address, two registers

    // ================================================
    // Wishbone classic slave port
    // ================================================
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0]    dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [DATA_WIDTH-1:0] dat_r;
    } wb_rsp_t;

    // Receiver status, overrun in bit 1 and frame error in bit 0
    typedef struct packed {
        logic overrun;
        logic frame_err;
    } uart_rx_status_t;

    typedef enum logic [WB_ADDR_WIDTH-1:0] {
        REG_DATA   = WB_ADDR_WIDTH'(0),   // Write sends, read returns rx byte
        REG_STATUS = WB_ADDR_WIDTH'(1)    // Read only
    } uart_reg_addr_t;

    // ================================================
    // Engine states
    // ================================================
    typedef enum logic [2:0] {
        S_UART_RX_IDLE,
        S_UART_RX_VALIDATE_START,
        S_UART_RX_READ_DATA,
        S_UART_RX_STOP,
        S_UART_RX_DATA_READY
    } uart_fsm_state_t;

    typedef enum logic [1:0] {
        S_UART_TX_IDLE,
        S_UART_TX_START,
        S_UART_TX_DATA,
        S_UART_TX_STOP
    } uart_tx_state_t;

endpackage
